//--- include/panel_macros.svh
`ifndef PANEL_MACROS_SVH
`define PANEL_MACROS_SVH

// number of front-panel buttons
`define PANEL_CHANNELS 4
`define PANEL_INDEX_WIDTH 2

// flip-flops per raw button line
`define PANEL_SYNC_STAGES 2

// debounce counter and register bus widths
`define PANEL_COUNT_WIDTH 16
`define PANEL_ADDR_WIDTH 2
`define PANEL_DATA_WIDTH 16

// limit after reset and the floor for written limits
`define PANEL_DEFAULT_LIMIT 20
`define PANEL_MIN_LIMIT 4

`endif

//--- source/panel_pkg.sv
`include "panel_macros.svh"

package panel_pkg;

	// one bit per button
	typedef logic [`PANEL_CHANNELS-1:0] channel_mask_t;
	typedef logic [`PANEL_INDEX_WIDTH-1:0] channel_index_t;

	// debounce run length in clock cycles
	typedef logic [`PANEL_COUNT_WIDTH-1:0] debounce_count_t;

	// register bus
	typedef logic [`PANEL_ADDR_WIDTH-1:0] reg_addr_t;
	typedef logic [`PANEL_DATA_WIDTH-1:0] reg_data_t;

	typedef struct packed {
		reg_addr_t addr;
		reg_data_t data;
	} bus_write_t;

	// pressed is the new debounced level of the channel
	typedef struct packed {
		channel_index_t channel;
		logic pressed;
	} panel_event_t;

	typedef struct packed {
		debounce_count_t debounce_limit;
		channel_mask_t enable_mask;
	} panel_config_t;

	typedef enum logic {
		stable,
		settling
	} debounce_state_t;

endpackage

//--- source/input_synchronizer.sv
`timescale 1ns/100ps
`include "panel_macros.svh"

module input_synchronizer (
	input logic clock,
	input logic reset,
	input panel_pkg::channel_mask_t button_raw,
	output panel_pkg::channel_mask_t button_sync
);
	import panel_pkg::*;

	// stage 0 samples the asynchronous lines, the last stage is safe to use
	channel_mask_t [`PANEL_SYNC_STAGES-1:0] sync_chain;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			sync_chain <= '0;
		end else begin
			sync_chain <= {sync_chain[`PANEL_SYNC_STAGES-2:0], button_raw};
		end
	end

	assign button_sync = sync_chain[`PANEL_SYNC_STAGES-1];

endmodule

//--- source/button_debounce.sv
`timescale 1ns/100ps

module button_debounce (
	input logic clock,
	input logic reset,
	input logic button_sync,
	input panel_pkg::debounce_count_t debounce_limit,
	output logic debounced_state,
	output logic changed
);
	import panel_pkg::*;

	debounce_state_t state;
	debounce_count_t run_count;
	debounce_count_t next_count;
	logic differs;

	// input disagrees with the accepted level
	assign differs = button_sync != debounced_state;
	assign next_count = run_count + debounce_count_t'(1);

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state <= stable;
			run_count <= '0;
			debounced_state <= 1'b0;
			changed <= 1'b0;
		end else begin
			changed <= 1'b0;
			case (state)
				stable: begin
					if (differs) begin
						// first cycle of a new level
						state <= settling;
						run_count <= debounce_count_t'(1);
					end
				end
				settling: begin
					if (!differs) begin
						// bounced back before the limit
						state <= stable;
						run_count <= '0;
					end else if (next_count >= debounce_limit) begin
						// held for limit cycles, accept it
						state <= stable;
						run_count <= '0;
						debounced_state <= button_sync;
						changed <= 1'b1;
					end else begin
						run_count <= next_count;
					end
				end
				default: begin
					state <= stable;
					run_count <= '0;
				end
			endcase
		end
	end

endmodule

//--- source/panel_config_regs.sv
`timescale 1ns/100ps
`include "panel_macros.svh"

module panel_config_regs (
	input logic clock,
	input logic reset,
	input logic write_strobe,
	input panel_pkg::bus_write_t write_request,
	input logic read_strobe,
	input panel_pkg::reg_addr_t read_addr,
	input panel_pkg::channel_mask_t debounced_state,
	input logic event_valid,
	output panel_pkg::panel_config_t panel_config,
	output logic read_valid,
	output panel_pkg::reg_data_t read_data
);
	import panel_pkg::*;

	// register map
	localparam reg_addr_t limit_addr = 2'd0;
	localparam reg_addr_t mask_addr = 2'd1;
	localparam reg_addr_t state_addr = 2'd2;
	localparam reg_addr_t count_addr = 2'd3;

	panel_config_t config_q;
	reg_data_t event_count;
	debounce_count_t written_limit;
	reg_data_t read_word;

	// short limits would let a channel retrigger before its event drains
	always_comb begin
		written_limit = debounce_count_t'(write_request.data);
		if (written_limit < debounce_count_t'(`PANEL_MIN_LIMIT)) begin
			written_limit = debounce_count_t'(`PANEL_MIN_LIMIT);
		end
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			config_q.debounce_limit <= debounce_count_t'(`PANEL_DEFAULT_LIMIT);
			config_q.enable_mask <= '1;
			event_count <= '0;
		end else begin
			if (event_valid) begin
				event_count <= event_count + reg_data_t'(1);
			end
			if (write_strobe) begin
				case (write_request.addr)
					limit_addr: config_q.debounce_limit <= written_limit;
					mask_addr: config_q.enable_mask <= write_request.data[`PANEL_CHANNELS-1:0];
					// any value clears, overriding a same-cycle event
					count_addr: event_count <= '0;
					default: begin
					end
				endcase
			end
		end
	end

	always_comb begin
		case (read_addr)
			limit_addr: read_word = reg_data_t'(config_q.debounce_limit);
			mask_addr: read_word = reg_data_t'(config_q.enable_mask);
			state_addr: read_word = reg_data_t'(debounced_state);
			default: read_word = event_count;
		endcase
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			read_valid <= 1'b0;
		end else begin
			read_valid <= read_strobe;
		end
	end

	// data captured as it stood at the strobe
	always_ff @(posedge clock) begin
		if (read_strobe) begin
			read_data <= read_word;
		end
	end

	assign panel_config = config_q;

endmodule

//--- source/event_encoder.sv
`timescale 1ns/100ps
`include "panel_macros.svh"

module event_encoder (
	input logic clock,
	input logic reset,
	input panel_pkg::channel_mask_t changed,
	input panel_pkg::channel_mask_t debounced_state,
	input panel_pkg::channel_mask_t enable_mask,
	output logic event_valid,
	output panel_pkg::panel_event_t event_out
);
	import panel_pkg::*;

	channel_mask_t pending;
	channel_mask_t candidates;
	channel_mask_t pending_next;
	channel_index_t pick_index;
	logic pick_found;

	// new strobes join the queue directly so a lone change leaves next cycle
	// disabled channels drop out here and never queue
	assign candidates = (pending | changed) & enable_mask;

	// lowest channel wins, so scan downward and keep the last hit
	always_comb begin
		pick_found = 1'b0;
		pick_index = '0;
		for (int i = `PANEL_CHANNELS - 1; i >= 0; i--) begin
			if (candidates[i]) begin
				pick_found = 1'b1;
				pick_index = channel_index_t'(i);
			end
		end
	end

	always_comb begin
		pending_next = candidates;
		if (pick_found) begin
			pending_next[pick_index] = 1'b0;
		end
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			pending <= '0;
			event_valid <= 1'b0;
		end else begin
			pending <= pending_next;
			event_valid <= pick_found;
		end
	end

	// payload only meaningful with event_valid
	always_ff @(posedge clock) begin
		if (pick_found) begin
			event_out.channel <= pick_index;
			event_out.pressed <= debounced_state[pick_index];
		end
	end

endmodule

//--- source/panel_input_top.sv
`timescale 1ns/100ps
`include "panel_macros.svh"

module panel_input_top (
	input logic clock,
	input logic reset,
	input panel_pkg::channel_mask_t button_raw,
	input logic write_strobe,
	input panel_pkg::bus_write_t write_request,
	input logic read_strobe,
	input panel_pkg::reg_addr_t read_addr,
	output logic read_valid,
	output panel_pkg::reg_data_t read_data,
	output logic event_valid,
	output panel_pkg::panel_event_t event_out,
	output panel_pkg::channel_mask_t button_state
);
	import panel_pkg::*;

	channel_mask_t button_sync;
	channel_mask_t debounced_state;
	channel_mask_t changed;
	panel_config_t panel_config;

	input_synchronizer i_input_synchronizer (
		.clock(clock),
		.reset(reset),
		.button_raw(button_raw),
		.button_sync(button_sync)
	);

	// one debouncer per button, all sharing the limit register
	for (genvar ch = 0; ch < `PANEL_CHANNELS; ch++) begin : g_debounce
		button_debounce i_button_debounce (
			.clock(clock),
			.reset(reset),
			.button_sync(button_sync[ch]),
			.debounce_limit(panel_config.debounce_limit),
			.debounced_state(debounced_state[ch]),
			.changed(changed[ch])
		);
	end

	event_encoder i_event_encoder (
		.clock(clock),
		.reset(reset),
		.changed(changed),
		.debounced_state(debounced_state),
		.enable_mask(panel_config.enable_mask),
		.event_valid(event_valid),
		.event_out(event_out)
	);

	panel_config_regs i_panel_config_regs (
		.clock(clock),
		.reset(reset),
		.write_strobe(write_strobe),
		.write_request(write_request),
		.read_strobe(read_strobe),
		.read_addr(read_addr),
		.debounced_state(debounced_state),
		.event_valid(event_valid),
		.panel_config(panel_config),
		.read_valid(read_valid),
		.read_data(read_data)
	);

	assign button_state = debounced_state;

endmodule

//--- bench/panel_input_assert.sv
`timescale 1ns/100ps
`include "panel_macros.svh"

module panel_input_assert (
	input logic clock,
	input logic reset,
	input logic read_strobe,
	input logic read_valid,
	input logic event_valid,
	input panel_pkg::panel_event_t event_out,
	input panel_pkg::panel_config_t panel_config
);
	import panel_pkg::*;

	// running total, picked up by the testbench at the end
	int assertion_failures = 0;

	enabled_channel_only: assert property (@(posedge clock) disable iff (reset)
		event_valid |-> panel_config.enable_mask[event_out.channel])
		else begin
			assertion_failures++;
			$error("event on disabled channel %0d", event_out.channel);
		end

	limit_above_floor: assert property (@(posedge clock) disable iff (reset)
		panel_config.debounce_limit >= debounce_count_t'(`PANEL_MIN_LIMIT))
		else begin
			assertion_failures++;
			$error("stored debounce limit %0d below floor", panel_config.debounce_limit);
		end

	// read_valid exactly one cycle after the strobe, never otherwise
	read_follows_strobe: assert property (@(posedge clock) disable iff (reset)
		read_strobe |=> read_valid)
		else begin
			assertion_failures++;
			$error("read_valid missing after read_strobe");
		end

	read_only_after_strobe: assert property (@(posedge clock) disable iff (reset)
		read_valid |-> $past(read_strobe))
		else begin
			assertion_failures++;
			$error("read_valid without a read_strobe the cycle before");
		end

	no_repeat_channel: assert property (@(posedge clock) disable iff (reset)
		event_valid && $past(event_valid) |-> event_out.channel != $past(event_out.channel))
		else begin
			assertion_failures++;
			$error("two events in a row on channel %0d", event_out.channel);
		end

endmodule

//--- bench/panel_input_tb.sv
`timescale 1ns/100ps
`include "panel_macros.svh"

module panel_input_tb;
	import panel_pkg::*;

	// worst case in clock cycles for ten event bursts plus glitches and register traffic
	localparam int event_wait = `PANEL_DEFAULT_LIMIT + 8;
	localparam int test_cycles = 10 * (event_wait + 8) + 10 * 8 + 3 * event_wait + 60;
	localparam int watchdog_cycles = 2 * test_cycles;

	logic clock;
	logic reset;
	channel_mask_t button_raw;
	logic write_strobe;
	bus_write_t write_request;
	logic read_strobe;
	reg_addr_t read_addr;
	logic read_valid;
	reg_data_t read_data;
	logic event_valid;
	panel_event_t event_out;
	channel_mask_t button_state;

	int mismatch_count = 0;
	int failure_count = 0;
	int assertion_count = 0;
	int expected_events = 0;
	int current_limit = `PANEL_DEFAULT_LIMIT;
	integer seed;

	panel_input_top i_panel_input_top (
		.clock(clock),
		.reset(reset),
		.button_raw(button_raw),
		.write_strobe(write_strobe),
		.write_request(write_request),
		.read_strobe(read_strobe),
		.read_addr(read_addr),
		.read_valid(read_valid),
		.read_data(read_data),
		.event_valid(event_valid),
		.event_out(event_out),
		.button_state(button_state)
	);

	bind panel_input_top panel_input_assert i_panel_input_assert (
		.clock(clock),
		.reset(reset),
		.read_strobe(read_strobe),
		.read_valid(read_valid),
		.event_valid(event_valid),
		.event_out(event_out),
		.panel_config(panel_config)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clock);
		$display("watchdog expired after %0d cycles, the tests did not finish", watchdog_cycles);
		$display("Simulation failed");
		$finish;
	end

	task automatic compare_data(input string test_name, input reg_data_t expected,
			input reg_data_t actual);
		if (actual !== expected) begin
			$display("mismatch %s: expected %h, actual %h", test_name, expected, actual);
			mismatch_count++;
		end
	endtask

	task automatic compare_mask(input string test_name, input channel_mask_t expected,
			input channel_mask_t actual);
		if (actual !== expected) begin
			$display("mismatch %s: expected %b, actual %b", test_name, expected, actual);
			mismatch_count++;
		end
	endtask

	task automatic compare_event(input string test_name, input panel_event_t expected,
			input panel_event_t actual);
		if (actual !== expected) begin
			$display("mismatch %s: expected channel %0d pressed %b, actual channel %0d pressed %b",
				test_name, expected.channel, expected.pressed, actual.channel, actual.pressed);
			mismatch_count++;
		end
	endtask

	// every task below starts and ends just after a falling edge
	task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
		write_strobe = 1'b1;
		write_request.addr = addr;
		write_request.data = data;
		@(negedge clock);
		write_strobe = 1'b0;
	endtask

	task automatic check_reg(input string test_name, input reg_addr_t addr,
			input reg_data_t expected);
		read_strobe = 1'b1;
		read_addr = addr;
		@(negedge clock);
		read_strobe = 1'b0;
		if (!read_valid) begin
			$display("%s: read_valid did not follow the read of address %0d", test_name, addr);
			failure_count++;
		end else begin
			compare_data(test_name, expected, read_data);
		end
	endtask

	task automatic expect_quiet(input string test_name, input int cycles);
		repeat (cycles) begin
			@(negedge clock);
			if (event_valid) begin
				$display("%s: unexpected event on channel %0d", test_name, event_out.channel);
				failure_count++;
			end
		end
	endtask

	task automatic drive_and_idle(input string test_name, input channel_mask_t level,
			input int cycles);
		button_raw = level;
		expect_quiet(test_name, cycles);
	endtask

	// counts cycles from the input change that was just driven
	task automatic wait_for_event(input string test_name, output logic found);
		int cycles;
		found = 1'b0;
		cycles = 0;
		while (!found && cycles < current_limit + 8) begin
			@(negedge clock);
			cycles++;
			found = event_valid;
		end
		if (!found) begin
			$display("%s: no event within %0d cycles of the input change", test_name, cycles);
			failure_count++;
		end else if (cycles < current_limit + 2) begin
			$display("%s: event came after only %0d cycles with limit %0d", test_name, cycles,
				current_limit);
			failure_count++;
		end
	endtask

	// one event per set channel, lowest first, on consecutive cycles
	task automatic expect_burst(input string test_name, input channel_mask_t channels,
			input logic pressed);
		panel_event_t expected;
		logic found;
		logic first;
		first = 1'b1;
		found = 1'b1;
		expected_events += $countones(channels);
		for (int ch = 0; ch < `PANEL_CHANNELS; ch++) begin
			if (channels[ch] && found) begin
				expected.channel = channel_index_t'(ch);
				expected.pressed = pressed;
				if (first) begin
					wait_for_event(test_name, found);
					first = 1'b0;
				end else begin
					@(negedge clock);
					found = event_valid;
					if (!found) begin
						$display("%s: no event for channel %0d right after the previous one",
							test_name, ch);
						failure_count++;
					end
				end
				if (found) begin
					compare_event(test_name, expected, event_out);
				end
			end
		end
		expect_quiet(test_name, 4);
	endtask

	task automatic reset_defaults();
		string name;
		name = "reset_defaults";
		check_reg(name, 2'd0, reg_data_t'(`PANEL_DEFAULT_LIMIT));
		check_reg(name, 2'd1, 16'h000f);
		check_reg(name, 2'd2, 16'h0000);
		check_reg(name, 2'd3, 16'h0000);
		compare_mask(name, 4'b0000, button_state);
	endtask

	task automatic clean_press_release();
		string name;
		name = "clean_press_release";
		write_reg(2'd0, 16'd8);
		current_limit = 8;
		check_reg(name, 2'd0, 16'd8);
		button_raw = 4'b0100;
		expect_burst(name, 4'b0100, 1'b1);
		compare_mask(name, 4'b0100, button_state);
		button_raw = 4'b0000;
		expect_burst(name, 4'b0100, 1'b0);
		compare_mask(name, 4'b0000, button_state);
	endtask

	task automatic bounce_rejection();
		string name;
		int high_len;
		int low_len;
		name = "bounce_rejection";
		// glitches of 1 to 4 cycles stay well under the limit of 8
		for (int n = 0; n < 10; n++) begin
			high_len = 1 + ($unsigned($random(seed)) % 4);
			low_len = 1 + ($unsigned($random(seed)) % 4);
			drive_and_idle(name, 4'b0010, high_len);
			drive_and_idle(name, 4'b0000, low_len);
		end
		drive_and_idle(name, 4'b0000, current_limit + 8);
		compare_mask(name, 4'b0000, button_state);
		button_raw = 4'b0010;
		expect_burst(name, 4'b0010, 1'b1);
		compare_mask(name, 4'b0010, button_state);
		button_raw = 4'b0000;
		expect_burst(name, 4'b0010, 1'b0);
	endtask

	task automatic simultaneous_changes();
		string name;
		name = "simultaneous_changes";
		button_raw = 4'b1111;
		expect_burst(name, 4'b1111, 1'b1);
		compare_mask(name, 4'b1111, button_state);
		button_raw = 4'b0000;
		expect_burst(name, 4'b1111, 1'b0);
		compare_mask(name, 4'b0000, button_state);
	endtask

	task automatic mask_and_clamp();
		string name;
		name = "mask_and_clamp";
		write_reg(2'd1, 16'h0005);
		check_reg(name, 2'd1, 16'h0005);
		button_raw = 4'b1111;
		expect_burst(name, 4'b0101, 1'b1);
		check_reg(name, 2'd2, 16'h000f);
		compare_mask(name, 4'b1111, button_state);
		button_raw = 4'b0000;
		expect_burst(name, 4'b0101, 1'b0);
		check_reg(name, 2'd2, 16'h0000);
		write_reg(2'd1, 16'h000f);
		write_reg(2'd0, 16'd1);
		check_reg(name, 2'd0, reg_data_t'(`PANEL_MIN_LIMIT));
		write_reg(2'd0, 16'd8);
		check_reg(name, 2'd0, 16'd8);
	endtask

	task automatic event_counter();
		string name;
		name = "event_counter";
		check_reg(name, 2'd3, reg_data_t'(expected_events));
		write_reg(2'd3, 16'hbeef);
		expected_events = 0;
		check_reg(name, 2'd3, 16'h0000);
		button_raw = 4'b1000;
		expect_burst(name, 4'b1000, 1'b1);
		button_raw = 4'b0000;
		expect_burst(name, 4'b1000, 1'b0);
		check_reg(name, 2'd3, reg_data_t'(expected_events));
	endtask

	initial begin
		seed = 94;
		reset = 1'b1;
		button_raw = '0;
		write_strobe = 1'b0;
		write_request = '0;
		read_strobe = 1'b0;
		read_addr = '0;
		repeat (2) @(negedge clock);
		reset = 1'b0;
		@(negedge clock);

		reset_defaults();
		clean_press_release();
		bounce_rejection();
		simultaneous_changes();
		mask_and_clamp();
		event_counter();

		assertion_count = i_panel_input_top.i_panel_input_assert.assertion_failures;
		$display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
			mismatch_count, failure_count, assertion_count);
		if (mismatch_count == 0 && failure_count == 0 && assertion_count == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- files.f
+incdir+include
source/panel_pkg.sv
source/input_synchronizer.sv
source/button_debounce.sv
source/panel_config_regs.sv
source/event_encoder.sv
source/panel_input_top.sv
bench/panel_input_assert.sv
bench/panel_input_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the panel input testbench with Verilator and runs it
set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -j 0 \
	-f files.f \
	--top-module panel_input_tb \
	--Mdir "$build_dir" \
	-o panel_input_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$build_dir/panel_input_sim" +verilator+error+limit+100 > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -q "Simulation failed" "$log_file"; then
	exit 1
fi
exit 0
